// ==== hdl/booth_consts.svh ====
`ifndef BOOTH_CONSTS_SVH
`define BOOTH_CONSTS_SVH

// operand and product sizes
`define BOOTH_OP_WIDTH   8
`define BOOTH_PROD_WIDTH 16

// step counter, one Booth step per multiplier bit
`define BOOTH_CNT_WIDTH  4
`define BOOTH_STEPS      8

`endif

// ==== hdl/booth_pkg.sv ====
package booth_pkg;

    // controller states
    typedef enum logic {
        CTRL_IDLE = 1'b0,
        CTRL_RUN  = 1'b1
    } ctrl_state_t;

    // accumulator update per Booth step
    typedef enum logic [1:0] {
        ALU_PASS = 2'b00,
        ALU_ADD  = 2'b01,
        ALU_SUB  = 2'b10
    } alu_op_t;

endpackage

// ==== hdl/booth_controller.sv ====
`timescale 1ns/1ps

module booth_controller
    import booth_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    start,
    input  logic    count_done,
    input  logic    q0,
    input  logic    q_m1,

    output logic    busy,
    output logic    load,
    output logic    step_en,
    output logic    out_en,
    output alu_op_t alu_op
);

    ctrl_state_t state;
    ctrl_state_t next_state;

    // booth pair decode, valid only while stepping
    alu_op_t booth_op;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= CTRL_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // standard radix-2 rule on {q0, q_m1}
    always_comb begin
        case ({q0, q_m1})
            2'b10: begin
                // start of a run of ones
                booth_op = ALU_SUB;
            end
            2'b01: begin
                // end of a run of ones
                booth_op = ALU_ADD;
            end
            default: begin
                booth_op = ALU_PASS;
            end
        endcase
    end

    // next state and datapath controls
    always_comb begin
        next_state = state;
        load       = 1'b0;
        step_en    = 1'b0;
        out_en     = 1'b0;
        alu_op     = ALU_PASS;

        case (state)
            CTRL_IDLE: begin
                if (start) begin
                    // operands are captured on this edge
                    load       = 1'b1;
                    next_state = CTRL_RUN;
                end
            end
            CTRL_RUN: begin
                if (count_done) begin
                    // all steps done, hand result to product reg
                    out_en     = 1'b1;
                    next_state = CTRL_IDLE;
                end else begin
                    step_en = 1'b1;
                    alu_op  = booth_op;
                end
            end
            default: begin
                next_state = CTRL_IDLE;
            end
        endcase
    end

    // start is ignored for as long as this is high
    assign busy = (state == CTRL_RUN);

endmodule

// ==== hdl/booth_datapath.sv ====
`timescale 1ns/1ps

`include "booth_consts.svh"

module booth_datapath
    import booth_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          load,
    input  logic                          step_en,
    input  logic                          out_en,
    input  alu_op_t                       alu_op,
    input  logic [`BOOTH_OP_WIDTH-1:0]    multiplicand,
    input  logic [`BOOTH_OP_WIDTH-1:0]    multiplier,

    output logic                          q0,
    output logic                          q_m1,
    output logic                          count_done,
    output logic                          done,
    output logic [`BOOTH_PROD_WIDTH-1:0]  product
);

    // working registers
    logic [`BOOTH_OP_WIDTH-1:0]  acc;
    logic [`BOOTH_OP_WIDTH-1:0]  mult_q;
    logic                        extra_bit;
    logic [`BOOTH_OP_WIDTH-1:0]  mcand;
    logic [`BOOTH_CNT_WIDTH-1:0] count;

    // alu works one bit wider than the operands
    // so that acc - (-128) keeps its true sign before the shift
    logic [`BOOTH_OP_WIDTH:0]    acc_ext;
    logic [`BOOTH_OP_WIDTH:0]    mcand_ext;
    logic [`BOOTH_OP_WIDTH:0]    alu_out;

    assign acc_ext   = {acc[`BOOTH_OP_WIDTH-1], acc};
    assign mcand_ext = {mcand[`BOOTH_OP_WIDTH-1], mcand};

    always_comb begin
        case (alu_op)
            ALU_ADD: begin
                alu_out = acc_ext + mcand_ext;
            end
            ALU_SUB: begin
                alu_out = acc_ext - mcand_ext;
            end
            default: begin
                alu_out = acc_ext;
            end
        endcase
    end

    // acc, multiplier and extra bit as one shift chain
    // the arithmetic shift drops the guard bit out of the top
    always_ff @(posedge clk) begin
        if (load) begin
            acc       <= '0;
            mult_q    <= multiplier;
            extra_bit <= 1'b0;
            mcand     <= multiplicand;
        end else if (step_en) begin
            acc       <= alu_out[`BOOTH_OP_WIDTH:1];
            mult_q    <= {alu_out[0], mult_q[`BOOTH_OP_WIDTH-1:1]};
            extra_bit <= mult_q[0];
        end
    end

    // step counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (load) begin
            count <= '0;
        end else if (step_en) begin
            count <= count + 1'b1;
        end
    end

    assign count_done = (count == `BOOTH_CNT_WIDTH'(`BOOTH_STEPS));

    // pair the controller looks at
    assign q0   = mult_q[0];
    assign q_m1 = extra_bit;

    // result is held until the next completion
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            product <= '0;
        end else if (out_en) begin
            product <= {acc, mult_q};
        end
    end

    // done is a single-cycle pulse after the product load
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else begin
            done <= out_en;
        end
    end

endmodule

// ==== hdl/booth_multiplier.sv ====
`timescale 1ns/1ps

`include "booth_consts.svh"

module booth_multiplier
    import booth_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          start,
    input  logic [`BOOTH_OP_WIDTH-1:0]    multiplicand,
    input  logic [`BOOTH_OP_WIDTH-1:0]    multiplier,

    output logic [`BOOTH_PROD_WIDTH-1:0]  product,
    output logic                          done,
    output logic                          busy
);

    // controller to datapath
    logic    load;
    logic    step_en;
    logic    out_en;
    alu_op_t alu_op;

    // datapath status back to the controller
    logic    q0;
    logic    q_m1;
    logic    count_done;

    booth_controller ctrl0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .count_done (count_done),
        .q0         (q0),
        .q_m1       (q_m1),
        .busy       (busy),
        .load       (load),
        .step_en    (step_en),
        .out_en     (out_en),
        .alu_op     (alu_op)
    );

    // operands are sampled only on the load cycle
    booth_datapath dp0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .load         (load),
        .step_en      (step_en),
        .out_en       (out_en),
        .alu_op       (alu_op),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .q0           (q0),
        .q_m1         (q_m1),
        .count_done   (count_done),
        .done         (done),
        .product      (product)
    );

endmodule

// ==== test/booth_multiplier_assertions.sv ====
`timescale 1ns/1ps

module booth_multiplier_assertions (
    input logic clk,
    input logic rst_n,
    input logic done,
    input logic busy
);

    // done is a single-cycle pulse
    assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done)
        else $error("done stayed high for more than one cycle");

    // a completion only ends a running operation
    assert property (@(posedge clk) disable iff (!rst_n)
        $rose(done) |-> $past(busy))
        else $error("done rose without a running operation");

    // busy drops exactly when done rises
    assert property (@(posedge clk) disable iff (!rst_n)
        $fell(busy) |-> $rose(done))
        else $error("busy fell without done");

endmodule

bind booth_multiplier booth_multiplier_assertions asrt0 (
    .clk   (clk),
    .rst_n (rst_n),
    .done  (done),
    .busy  (busy)
);

// ==== test/booth_multiplier_tb.sv ====
`timescale 1ns/1ps

`include "booth_consts.svh"

module booth_multiplier_tb;

    localparam int CLK_PERIOD     = 10;
    localparam int RESET_CYCLES   = 4;
    localparam int NUM_FIXED      = 8;
    localparam int NUM_RANDOM     = 12;
    localparam int NUM_TESTS      = NUM_FIXED + NUM_RANDOM;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * 12 + 50;
    // one edge per Booth step, then the edge that loads the product
    localparam int DONE_EDGES     = `BOOTH_STEPS + 1;
    localparam int WAIT_LIMIT     = 2 * DONE_EDGES;

    logic                         clk;
    logic                         rst_n;
    logic                         start;
    logic [`BOOTH_OP_WIDTH-1:0]   multiplicand;
    logic [`BOOTH_OP_WIDTH-1:0]   multiplier;
    logic [`BOOTH_PROD_WIDTH-1:0] product;
    logic                         done;
    logic                         busy;

    // stimulus table, one entry per operation
    string                        tbl_name [$];
    logic [`BOOTH_OP_WIDTH-1:0]   tbl_a    [$];
    logic [`BOOTH_OP_WIDTH-1:0]   tbl_b    [$];
    logic [`BOOTH_PROD_WIDTH-1:0] tbl_exp  [$];
    // start this entry in the done cycle of the previous one
    bit                           tbl_b2b  [$];

    integer                       seed;
    logic [`BOOTH_PROD_WIDTH-1:0] last_product;

    booth_multiplier dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .product      (product),
        .done         (done),
        .busy         (busy)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            fail_run($sformatf("FAILED %s: expected 0x%0h, actual 0x%0h",
                               name, expected, actual));
        end
    endtask

    task automatic add_entry(input string name,
                             input logic [`BOOTH_OP_WIDTH-1:0] a,
                             input logic [`BOOTH_OP_WIDTH-1:0] b,
                             input logic [`BOOTH_PROD_WIDTH-1:0] expected,
                             input bit b2b);
        tbl_name.push_back(name);
        tbl_a.push_back(a);
        tbl_b.push_back(b);
        tbl_exp.push_back(expected);
        tbl_b2b.push_back(b2b);
    endtask

    task automatic build_table();
        logic [31:0]                rnd;
        logic [`BOOTH_OP_WIDTH-1:0] a;
        logic [`BOOTH_OP_WIDTH-1:0] b;
        int                         pa;
        int                         pb;
        int                         prod;
        int                         k;

        // hand-worked signed products
        add_entry("zero",          8'h00, 8'h5a, 16'h0000, 1'b0);
        add_entry("one",           8'h01, 8'h7b, 16'h007b, 1'b1);
        add_entry("minus_one",     8'hff, 8'h13, 16'hffed, 1'b0);
        add_entry("min_times_min", 8'h80, 8'h80, 16'h4000, 1'b1);
        add_entry("max_times_min", 8'h7f, 8'h80, 16'hc080, 1'b1);
        add_entry("alt_55_aa",     8'h55, 8'haa, 16'he372, 1'b0);
        add_entry("alt_aa_aa",     8'haa, 8'haa, 16'h1ce4, 1'b1);
        add_entry("minus_one_sq",  8'hff, 8'hff, 16'h0001, 1'b0);

        for (k = 0; k < NUM_RANDOM; k++) begin
            rnd  = $random(seed);
            a    = rnd[`BOOTH_OP_WIDTH-1:0];
            rnd  = $random(seed);
            b    = rnd[`BOOTH_OP_WIDTH-1:0];
            // two's complement operands, full-width signed product
            pa   = 32'($signed(a));
            pb   = 32'($signed(b));
            prod = pa * pb;
            add_entry($sformatf("random_%0d", k), a, b,
                      prod[`BOOTH_PROD_WIDTH-1:0], k[0]);
        end
    endtask

    // idle gap with new operands, product must not move
    task automatic check_hold(input int idx);
        multiplicand = tbl_a[idx] ^ 8'ha5;
        multiplier   = ~tbl_b[idx];
        repeat (2) begin
            @(posedge clk);
            #1;
            check_value({tbl_name[idx], " hold done"}, 32'd0, 32'(done));
            check_value({tbl_name[idx], " hold busy"}, 32'd0, 32'(busy));
            check_value({tbl_name[idx], " hold product"},
                        32'(last_product), 32'(product));
        end
    endtask

    // called just after an edge, with the DUT idle or in its done cycle
    task automatic run_operation(input int idx);
        logic [`BOOTH_OP_WIDTH-1:0] a;
        logic [`BOOTH_OP_WIDTH-1:0] b;
        int                         edges;

        a            = tbl_a[idx];
        b            = tbl_b[idx];
        multiplicand = a;
        multiplier   = b;
        start        = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        check_value({tbl_name[idx], " busy after accept"}, 32'd1, 32'(busy));
        check_value({tbl_name[idx], " done after accept"}, 32'd0, 32'(done));

        edges = 0;
        while (done !== 1'b1) begin
            if (edges >= WAIT_LIMIT) begin
                fail_run($sformatf("%s never raised done within %0d cycles",
                                   tbl_name[idx], WAIT_LIMIT));
            end else begin
                @(posedge clk);
                #1;
                edges++;
                if (edges == 2) begin
                    // stray start and new operands in mid-run
                    start        = 1'b1;
                    multiplicand = ~a;
                    multiplier   = b ^ 8'h3c;
                end else if (edges == 3) begin
                    start = 1'b0;
                end
                if (done !== 1'b1) begin
                    check_value({tbl_name[idx], " busy while running"},
                                32'd1, 32'(busy));
                end
            end
        end

        check_value({tbl_name[idx], " edges to done"}, DONE_EDGES, edges);
        check_value({tbl_name[idx], " busy with done"}, 32'd0, 32'(busy));
        check_value({tbl_name[idx], " product"}, 32'(tbl_exp[idx]), 32'(product));
        last_product = tbl_exp[idx];
    endtask

    initial begin
        int i;

        rst_n        = 1'b0;
        start        = 1'b0;
        multiplicand = '0;
        multiplier   = '0;
        seed         = 32'ha1b596e1;
        last_product = '0;

        build_table();

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_value("reset product", 32'd0, 32'(product));
        check_value("reset done", 32'd0, 32'(done));
        check_value("reset busy", 32'd0, 32'(busy));

        for (i = 0; i < tbl_name.size(); i++) begin
            if (!tbl_b2b[i] || i == 0) begin
                check_hold(i);
            end
            run_operation(i);
        end

        // last done pulse has to end on its own
        @(posedge clk);
        #1;
        check_value("final done", 32'd0, 32'(done));
        check_value("final product", 32'(last_product), 32'(product));

        $display("Testbench passed");
        $finish;
    end

    // watchdog
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        fail_run($sformatf("timeout, the tests did not finish within %0d clock cycles",
                           TIMEOUT_CYCLES));
    end

endmodule

// ==== booth_multiplier.f ====
+incdir+hdl
hdl/booth_pkg.sv
hdl/booth_controller.sv
hdl/booth_datapath.sv
hdl/booth_multiplier.sv
test/booth_multiplier_assertions.sv
test/booth_multiplier_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := booth_multiplier_tb
FILELIST  := booth_multiplier.f
OBJ_DIR   := obj_dir
PASS_MSG  := Testbench passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
